// File: source/aib_adapt_pkg.sv
// -------------------------------------------------------------------------
// Widths, FIFO depth and mode encodings shared by the transmit channel.
// Referenced by scoped name from every block of the design.
// -------------------------------------------------------------------------
`default_nettype none

package aib_adapt_pkg;

  // Transmit word
  localparam int DATA_W      = 40;

  // Phase-compensation FIFO geometry
  localparam int FIFO_DEPTH  = 8;
  localparam int ADDR_W      = 3;   // Wraps naturally at FIFO_DEPTH
  localparam int COUNT_W     = 4;   // Holds 0 .. FIFO_DEPTH

  // Read-delay setting, 0 to 7 extra cycles
  localparam int RD_DELAY_W  = 3;

  // Flops per reset synchronizer
  localparam int SYNC_STAGES = 2;

  typedef logic [DATA_W-1:0] word_t;

  // FIFO mode, 01 and 10 behave like phase compensation
  typedef enum logic [1:0] {
    TX_FIFO_PHCOMP = 2'b00,
    TX_FIFO_REG    = 2'b11
  } tx_fifo_mode_e;

  // Loopback selection
  typedef enum logic [1:0] {
    TX_LPBK_NONE   = 2'b00,   // Fabric data to AIB
    TX_LPBK_2      = 2'b01,   // AIB receive word straight back
    TX_LPBK_3_REG  = 2'b10,   // Receive register word into register path
    TX_LPBK_3_FIFO = 2'b11    // Receive FIFO word into FIFO path
  } tx_lpbk_mode_e;

endpackage

`default_nettype wire

// File: source/aib_tx_fifo_if.sv
// -------------------------------------------------------------------------
// FIFO path output bundle, read word plus status, towards the channel block
// -------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

interface aib_tx_fifo_if;

  aib_adapt_pkg::word_t fifo_dout;     // Registered read word
  logic                 fifo_empty;    // No entry written yet
  logic                 fifo_full;     // Fill count at FIFO_DEPTH
  logic                 tx_fifo_ready; // Read side running

  // Driven by the FIFO path
  modport source (
    output fifo_dout,
    output fifo_empty,
    output fifo_full,
    output tx_fifo_ready
  );

  // Consumed by the channel block
  modport sink (
    input fifo_dout,
    input fifo_empty,
    input fifo_full,
    input tx_fifo_ready
  );

endinterface

`default_nettype wire

// File: source/aib_adapttxdp_reg.sv
// -------------------------------------------------------------------------
// Register-mode transmit path, one retiming flop stage on the read clock
// -------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module aib_adapttxdp_reg (
  input  logic                         m_ns_fwd_clk,
  input  logic                         txrd_rstn,      // Synchronized read reset
  input  aib_adapt_pkg::tx_fifo_mode_e r_tx_fifo_mode,
  input  aib_adapt_pkg::word_t         reg_din,        // Fabric or loopback word
  output aib_adapt_pkg::word_t         reg_dout
);

  logic                 reg_mode;
  aib_adapt_pkg::word_t reg_q;

  assign reg_mode = (r_tx_fifo_mode == aib_adapt_pkg::TX_FIFO_REG);

  // Single stage
  // Outside register mode the flops load zero and stay quiet
  always_ff @(posedge m_ns_fwd_clk or negedge txrd_rstn) begin
    if (!txrd_rstn) begin
      reg_q <= '0;
    end else if (reg_mode) begin
      reg_q <= reg_din;
    end else begin
      reg_q <= '0;
    end
  end

  assign reg_dout = reg_q;

endmodule

`default_nettype wire

// File: source/aib_adapttxdp_txdp.sv
// -------------------------------------------------------------------------
// Phase-compensation FIFO path. Writes every cycle out of reset, starts
// reading once the fill count reaches the read delay plus one.
// -------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module aib_adapttxdp_txdp (
  input  logic                                 m_ns_fwd_clk,
  input  logic                                 txwr_rstn,      // Write-side reset
  input  logic                                 txrd_rstn,      // Read-side reset
  input  logic [aib_adapt_pkg::RD_DELAY_W-1:0] r_tx_phcomp_rd_delay,
  input  aib_adapt_pkg::word_t                 fifo_din,
  aib_tx_fifo_if.source                        fifo
);

  // Storage
  aib_adapt_pkg::word_t mem [aib_adapt_pkg::FIFO_DEPTH];

  // Pointers and occupancy
  logic [aib_adapt_pkg::ADDR_W-1:0]  wr_ptr;
  logic [aib_adapt_pkg::ADDR_W-1:0]  rd_ptr;
  logic [aib_adapt_pkg::COUNT_W-1:0] fill_cnt;
  logic [aib_adapt_pkg::COUNT_W-1:0] start_lvl;

  // Control
  logic                 wr_en;
  logic                 rd_en;
  logic                 rd_started;
  aib_adapt_pkg::word_t rd_word;

  // Fill level at which reading begins, delay + 1 (1 .. 8)
  assign start_lvl = {1'b0, r_tx_phcomp_rd_delay} + 1'b1;

  // No back-pressure, the fabric side writes every cycle out of reset
  assign wr_en = txwr_rstn;

  // Once started, one read per cycle keeps the level fixed
  assign rd_en = txrd_rstn & (rd_started | (fill_cnt >= start_lvl));

  always_ff @(posedge m_ns_fwd_clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= fifo_din;
    end
  end

  // Write pointer
  always_ff @(posedge m_ns_fwd_clk or negedge txwr_rstn) begin
    if (!txwr_rstn) begin
      wr_ptr <= '0;
    end else if (wr_en) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

  // Occupancy tracks writes minus reads
  always_ff @(posedge m_ns_fwd_clk or negedge txwr_rstn) begin
    if (!txwr_rstn) begin
      fill_cnt <= '0;
    end else begin
      case ({wr_en, rd_en})
        2'b10:   fill_cnt <= fill_cnt + 1'b1;
        2'b01:   fill_cnt <= fill_cnt - 1'b1;
        default: fill_cnt <= fill_cnt;   // Both or neither
      endcase
    end
  end

  // Read side, registered word
  always_ff @(posedge m_ns_fwd_clk or negedge txrd_rstn) begin
    if (!txrd_rstn) begin
      rd_ptr     <= '0;
      rd_started <= 1'b0;
      rd_word    <= '0;
    end else if (rd_en) begin
      rd_ptr     <= rd_ptr + 1'b1;
      rd_started <= 1'b1;              // Sticky until reset
      rd_word    <= mem[rd_ptr];
    end
  end

  // Status towards the channel block
  assign fifo.fifo_dout     = rd_word;
  assign fifo.tx_fifo_ready = rd_started;
  assign fifo.fifo_empty    = (fill_cnt == '0);
  assign fifo.fifo_full     = (fill_cnt == aib_adapt_pkg::FIFO_DEPTH);  // Delay 7 only

endmodule

`default_nettype wire

// File: source/aib_adapt_txchnl.sv
// -------------------------------------------------------------------------
// Channel control. Loopback decode, path input steering, reset
// synchronizers and final output word selection.
// -------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module aib_adapt_txchnl (
  input  logic                         m_ns_fwd_clk,
  input  logic                         arst_n,
  input  aib_adapt_pkg::tx_fifo_mode_e r_tx_fifo_mode,
  input  aib_adapt_pkg::tx_lpbk_mode_e r_tx_adapter_lpbk_mode,
  input  aib_adapt_pkg::word_t         data_in,          // From fabric
  input  aib_adapt_pkg::word_t         rx_reg_dout,      // Rx register loopback
  input  aib_adapt_pkg::word_t         rx_fifo_data_out, // Rx FIFO loopback
  input  aib_adapt_pkg::word_t         din,              // Rx AIB io loopback
  input  aib_adapt_pkg::word_t         reg_dout,
  aib_tx_fifo_if.sink                  fifo,
  output aib_adapt_pkg::word_t         reg_din,
  output aib_adapt_pkg::word_t         fifo_din,
  output logic                         txwr_rstn,
  output logic                         txrd_rstn,
  output aib_adapt_pkg::word_t         dout,
  output logic                         tx_fifo_ready,
  output logic                         fifo_empty,
  output logic                         fifo_full
);

  logic loopback2;
  logic loopback3_reg;
  logic loopback3_fifo;

  // Reset synchronizer chains, bit 0 first
  logic [aib_adapt_pkg::SYNC_STAGES-1:0] txwr_sync;
  logic [aib_adapt_pkg::SYNC_STAGES-1:0] txrd_sync;

  // Loopback decode
  always_comb begin
    loopback2      = 1'b0;
    loopback3_reg  = 1'b0;
    loopback3_fifo = 1'b0;
    case (r_tx_adapter_lpbk_mode)
      aib_adapt_pkg::TX_LPBK_NONE:   loopback2 = 1'b0;
      aib_adapt_pkg::TX_LPBK_2:      loopback2 = 1'b1;
      aib_adapt_pkg::TX_LPBK_3_REG:  loopback3_reg = 1'b1;
      aib_adapt_pkg::TX_LPBK_3_FIFO: loopback3_fifo = 1'b1;
      default:                       loopback2 = 1'b0;
    endcase
  end

  // Path inputs
  assign reg_din  = loopback3_reg  ? rx_reg_dout      : data_in;
  assign fifo_din = loopback3_fifo ? rx_fifo_data_out : data_in;

  // Assert at once on arst_n, release on the second clock edge
  always_ff @(posedge m_ns_fwd_clk or negedge arst_n) begin
    if (!arst_n) begin
      txwr_sync <= '0;
      txrd_sync <= '0;
    end else begin
      txwr_sync <= {txwr_sync[aib_adapt_pkg::SYNC_STAGES-2:0], 1'b1};
      txrd_sync <= {txrd_sync[aib_adapt_pkg::SYNC_STAGES-2:0], 1'b1};
    end
  end

  assign txwr_rstn = txwr_sync[aib_adapt_pkg::SYNC_STAGES-1];
  assign txrd_rstn = txrd_sync[aib_adapt_pkg::SYNC_STAGES-1];

  // Output word, loopback 2 wins, then register mode, then FIFO once ready
  always_comb begin
    if (loopback2) begin
      dout = din;
    end else if (r_tx_fifo_mode == aib_adapt_pkg::TX_FIFO_REG) begin
      dout = reg_dout;
    end else if (fifo.tx_fifo_ready) begin
      dout = fifo.fifo_dout;
    end else begin
      dout = '0;                        // FIFO still filling
    end
  end

  // FIFO status to the pins
  assign tx_fifo_ready = fifo.tx_fifo_ready;
  assign fifo_empty    = fifo.fifo_empty;
  assign fifo_full     = fifo.fifo_full;

endmodule

`default_nettype wire

// File: source/aib_adapt_tx_top.sv
// -------------------------------------------------------------------------
// Transmit channel top. Connects channel control, register path and FIFO
// path. Mode inputs are plain vectors, cast to enumerations at instances.
// -------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module aib_adapt_tx_top (
  input  logic                                 m_ns_fwd_clk,
  input  logic                                 arst_n,
  input  logic [aib_adapt_pkg::DATA_W-1:0]     data_in,
  input  logic [aib_adapt_pkg::DATA_W-1:0]     rx_reg_dout,
  input  logic [aib_adapt_pkg::DATA_W-1:0]     rx_fifo_data_out,
  input  logic [aib_adapt_pkg::DATA_W-1:0]     din,
  input  logic [1:0]                           r_tx_fifo_mode,
  input  logic [1:0]                           r_tx_adapter_lpbk_mode,
  input  logic [aib_adapt_pkg::RD_DELAY_W-1:0] r_tx_phcomp_rd_delay,
  output logic [aib_adapt_pkg::DATA_W-1:0]     dout,
  output logic                                 tx_fifo_ready,
  output logic                                 fifo_empty,
  output logic                                 fifo_full
);

  aib_adapt_pkg::word_t reg_din;
  aib_adapt_pkg::word_t reg_dout;
  aib_adapt_pkg::word_t fifo_din;
  logic                 txwr_rstn;
  logic                 txrd_rstn;

  aib_tx_fifo_if fifo_if ();

  aib_adapt_txchnl txchnl (
    .m_ns_fwd_clk           (m_ns_fwd_clk),
    .arst_n                 (arst_n),
    .r_tx_fifo_mode         (aib_adapt_pkg::tx_fifo_mode_e'(r_tx_fifo_mode)),
    .r_tx_adapter_lpbk_mode (aib_adapt_pkg::tx_lpbk_mode_e'(r_tx_adapter_lpbk_mode)),
    .data_in                (data_in),
    .rx_reg_dout            (rx_reg_dout),
    .rx_fifo_data_out       (rx_fifo_data_out),
    .din                    (din),
    .reg_dout               (reg_dout),
    .fifo                   (fifo_if.sink),
    .reg_din                (reg_din),
    .fifo_din               (fifo_din),
    .txwr_rstn              (txwr_rstn),
    .txrd_rstn              (txrd_rstn),
    .dout                   (dout),
    .tx_fifo_ready          (tx_fifo_ready),
    .fifo_empty             (fifo_empty),
    .fifo_full              (fifo_full)
  );

  // Register-mode path
  aib_adapttxdp_reg txdp_reg (
    .m_ns_fwd_clk   (m_ns_fwd_clk),
    .txrd_rstn      (txrd_rstn),
    .r_tx_fifo_mode (aib_adapt_pkg::tx_fifo_mode_e'(r_tx_fifo_mode)),
    .reg_din        (reg_din),
    .reg_dout       (reg_dout)
  );

  // Phase-compensation FIFO path
  aib_adapttxdp_txdp tx_datapath (
    .m_ns_fwd_clk         (m_ns_fwd_clk),
    .txwr_rstn            (txwr_rstn),
    .txrd_rstn            (txrd_rstn),
    .r_tx_phcomp_rd_delay (r_tx_phcomp_rd_delay),
    .fifo_din             (fifo_din),
    .fifo                 (fifo_if.source)
  );

endmodule

`default_nettype wire

// File: verification/aib_adapt_tx_tb.sv
// --------------------------------------------------------------------------
// Testbench for the transmit channel top. Runs each FIFO mode, read delay
// and loopback in its own reset phase and checks dout and status by assertion.
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module aib_adapt_tx_tb;

  localparam int HALF_PERIOD = 50;       // 100 ns clock
  localparam int RST_CYCLES  = 8;
  localparam int RUN_CYCLES  = 24;       // Enough for ready at delay 7 plus data
  localparam int NUM_PHASES  = 14;
  localparam int CYCLE_LIMIT = NUM_PHASES * (RST_CYCLES + RUN_CYCLES + 1) + 40;

  // Mode encodings as the channel defines them
  localparam logic [1:0] FIFO_PHCOMP = 2'b00;
  localparam logic [1:0] FIFO_REG    = 2'b11;
  localparam logic [1:0] LPBK_NONE   = 2'b00;
  localparam logic [1:0] LPBK_2      = 2'b01;
  localparam logic [1:0] LPBK_3_REG  = 2'b10;
  localparam logic [1:0] LPBK_3_FIFO = 2'b11;

  // DUT inputs
  logic        m_ns_fwd_clk;
  logic        arst_n;
  logic [39:0] data_in;
  logic [39:0] rx_reg_dout;
  logic [39:0] rx_fifo_data_out;
  logic [39:0] din;
  logic [1:0]  r_tx_fifo_mode;
  logic [1:0]  r_tx_adapter_lpbk_mode;
  logic [2:0]  r_tx_phcomp_rd_delay;

  // DUT outputs
  logic [39:0] dout;
  logic        tx_fifo_ready;
  logic        fifo_empty;
  logic        fifo_full;

  // Reference model state
  logic [39:0] fifo_hist [0:RUN_CYCLES];   // FIFO-side word per edge since release
  logic [39:0] reg_hist  [0:RUN_CYCLES];   // Register-side word per edge
  logic [39:0] cur_fifo_word;
  logic [39:0] cur_reg_word;
  logic [39:0] exp_dout;
  logic        exp_ready;
  logic        exp_written;
  logic        in_reset;
  logic        checking;
  int          edges;                      // Rising edges since arst_n release
  integer      seed;

  // Bookkeeping
  int cycles;
  int reset_errs;
  int dout_errs;
  int status_errs;

  aib_adapt_tx_top UUT (
    .m_ns_fwd_clk           (m_ns_fwd_clk),
    .arst_n                 (arst_n),
    .data_in                (data_in),
    .rx_reg_dout            (rx_reg_dout),
    .rx_fifo_data_out       (rx_fifo_data_out),
    .din                    (din),
    .r_tx_fifo_mode         (r_tx_fifo_mode),
    .r_tx_adapter_lpbk_mode (r_tx_adapter_lpbk_mode),
    .r_tx_phcomp_rd_delay   (r_tx_phcomp_rd_delay),
    .dout                   (dout),
    .tx_fifo_ready          (tx_fifo_ready),
    .fifo_empty             (fifo_empty),
    .fifo_full              (fifo_full)
  );

  always #HALF_PERIOD m_ns_fwd_clk = ~m_ns_fwd_clk;

  // Reset state while arst_n is held low
  assert property (@(posedge m_ns_fwd_clk) disable iff (!checking)
    in_reset |-> (dout == '0 && !tx_fifo_ready && fifo_empty && !fifo_full))
    else begin
      reset_errs++;
      $display("** Error: in reset dout = %h tx_fifo_ready = %h fifo_empty = %h fifo_full = %h",
               $sampled(dout), $sampled(tx_fifo_ready), $sampled(fifo_empty),
               $sampled(fifo_full));
    end

  assert property (@(posedge m_ns_fwd_clk) disable iff (!checking)
    dout == exp_dout)
    else begin
      dout_errs++;
      $display("** Error: dout = %h, expected %h", $sampled(dout), $sampled(exp_dout));
    end

  assert property (@(posedge m_ns_fwd_clk) disable iff (!checking)
    tx_fifo_ready == exp_ready)
    else begin
      status_errs++;
      $display("** Error: tx_fifo_ready = %h, expected %h",
               $sampled(tx_fifo_ready), $sampled(exp_ready));
    end

  // Full only when the level settles at the depth
  assert property (@(posedge m_ns_fwd_clk) disable iff (!checking)
    exp_ready |-> (fifo_full == (r_tx_phcomp_rd_delay == 3'd7)))
    else begin
      status_errs++;
      $display("** Error: fifo_full = %h, expected %h at read delay %h",
               $sampled(fifo_full), $sampled(r_tx_phcomp_rd_delay == 3'd7),
               $sampled(r_tx_phcomp_rd_delay));
    end

  assert property (@(posedge m_ns_fwd_clk) disable iff (!checking)
    fifo_empty == !exp_written)
    else begin
      status_errs++;
      $display("** Error: fifo_empty = %h, expected %h",
               $sampled(fifo_empty), $sampled(!exp_written));
    end

  // Run limit
  always @(posedge m_ns_fwd_clk) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      $display("Timeout: stimulus still running after %0d clock cycles", CYCLE_LIMIT);
      $display("Test failed");
      $finish;
    end
  end

  // New random words on all data inputs and the word each path will sample
  task automatic drive_words();
    logic [63:0] rnd;
    rnd = {$random(seed), $random(seed)};
    data_in = rnd[39:0];
    rnd = {$random(seed), $random(seed)};
    rx_reg_dout = rnd[39:0];
    rnd = {$random(seed), $random(seed)};
    rx_fifo_data_out = rnd[39:0];
    rnd = {$random(seed), $random(seed)};
    din = rnd[39:0];
    cur_fifo_word = (r_tx_adapter_lpbk_mode == LPBK_3_FIFO) ? rx_fifo_data_out : data_in;
    cur_reg_word  = (r_tx_adapter_lpbk_mode == LPBK_3_REG)  ? rx_reg_dout      : data_in;
  endtask

  // Expected outputs for the window up to the next rising edge
  task automatic update_expected();
    int lat;
    lat         = int'(r_tx_phcomp_rd_delay) + 1;
    exp_ready   = (edges >= lat + 3);       // Two sync edges, one write, lat reads
    exp_written = (edges >= 3);
    if (r_tx_adapter_lpbk_mode == LPBK_2) begin
      exp_dout = din;
    end else if (r_tx_fifo_mode == FIFO_REG) begin
      exp_dout = (edges >= 3) ? reg_hist[edges] : '0;
    end else begin
      exp_dout = exp_ready ? fifo_hist[edges - lat] : '0;
    end
  endtask

  // One reset phase with a fixed configuration, then free-running data
  task automatic run_phase(input logic [1:0] fifo_mode, input logic [1:0] lpbk_mode,
                           input logic [2:0] rd_delay);
    @(negedge m_ns_fwd_clk);
    arst_n                 = 1'b0;
    in_reset               = 1'b1;
    r_tx_fifo_mode         = fifo_mode;
    r_tx_adapter_lpbk_mode = lpbk_mode;
    r_tx_phcomp_rd_delay   = rd_delay;
    data_in                = '0;
    rx_reg_dout            = '0;
    rx_fifo_data_out       = '0;
    din                    = '0;          // Keeps loopback 2 output at zero in reset
    edges                  = 0;
    checking               = 1'b1;
    update_expected();
    repeat (RST_CYCLES) @(negedge m_ns_fwd_clk);
    arst_n   = 1'b1;
    in_reset = 1'b0;
    drive_words();
    update_expected();
    repeat (RUN_CYCLES) begin
      @(negedge m_ns_fwd_clk);
      edges++;
      fifo_hist[edges] = cur_fifo_word;   // Sampled at the edge just passed
      reg_hist[edges]  = cur_reg_word;
      drive_words();
      update_expected();
    end
  endtask

  initial begin
    seed                   = 32'h7562;
    m_ns_fwd_clk           = 1'b0;
    arst_n                 = 1'b0;
    data_in                = '0;
    rx_reg_dout            = '0;
    rx_fifo_data_out       = '0;
    din                    = '0;
    r_tx_fifo_mode         = FIFO_PHCOMP;
    r_tx_adapter_lpbk_mode = LPBK_NONE;
    r_tx_phcomp_rd_delay   = '0;
    cur_fifo_word          = '0;
    cur_reg_word           = '0;
    exp_dout               = '0;
    exp_ready              = 1'b0;
    exp_written            = 1'b0;
    in_reset               = 1'b1;
    checking               = 1'b0;
    edges                  = 0;
    cycles                 = 0;
    reset_errs             = 0;
    dout_errs              = 0;
    status_errs            = 0;

    // Every read delay through the FIFO path
    for (int d = 0; d < 8; d++) begin
      run_phase(FIFO_PHCOMP, LPBK_NONE, 3'(d));
    end

    run_phase(FIFO_REG, LPBK_NONE, 3'd0);
    run_phase(FIFO_REG, LPBK_3_REG, 3'd2);
    run_phase(FIFO_PHCOMP, LPBK_3_FIFO, 3'd3);
    run_phase(2'b10, LPBK_3_FIFO, 3'd5);      // Mode 10 acts as phase compensation
    run_phase(FIFO_PHCOMP, LPBK_2, 3'd4);
    run_phase(FIFO_REG, LPBK_2, 3'd1);

    @(negedge m_ns_fwd_clk);
    $display("Errors: reset %0d, dout %0d, status %0d", reset_errs, dout_errs, status_errs);
    if (reset_errs + dout_errs + status_errs == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
source/aib_adapt_pkg.sv
source/aib_tx_fifo_if.sv
source/aib_adapttxdp_reg.sv
source/aib_adapttxdp_txdp.sv
source/aib_adapt_txchnl.sv
source/aib_adapt_tx_top.sv
verification/aib_adapt_tx_tb.sv

// File: Makefile
# Verilator build, run and lint for the AIB transmit channel

TOP = aib_adapt_tx_tb
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal \
	  --top-module $(TOP) -f compile.f -Mdir obj_dir

# Pass or fail comes from the log, not from the simulator exit status
run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -qx "Test completed successfully" $(LOG) || \
	  { echo "Simulation did not pass, see $(LOG)"; exit 1; }

lint:
	verilator --lint-only -Wall --timing --top-module aib_adapt_tx_top -f compile.f
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f compile.f

clean:
	rm -rf obj_dir $(LOG)
